// File: source/pio_consts.svh
/*
 * PIO bridge constants
 * Bus widths, peripheral port count and the time prescaler width
 */

`ifndef PIO_CONSTS_SVH
`define PIO_CONSTS_SVH

// Shared address/data bus and AXI-lite address and data width
`define PIO_NBITS 16
`define NUM_OF_PIO 4
`define PIO_SEL_NBITS 2

// current_time advances once per 2**TIME_BASE_NBITS cycles
`define TIME_BASE_NBITS 4
`define REAL_TIME_NBITS 24

`endif

// File: source/pio_pkg.sv
/*
 * PIO bridge types
 * Vector types for bus words, port indexes, port masks and time,
 * plus the sequencer state encoding
 */

`include "pio_consts.svh"

package pio_pkg;

        typedef logic [`PIO_NBITS-1:0] pio_word_t;
        typedef logic [`PIO_SEL_NBITS-1:0] pio_sel_t;
        typedef logic [`NUM_OF_PIO-1:0] pio_mask_t;
        typedef logic [`REAL_TIME_NBITS-1:0] real_time_t;

        typedef enum logic [1:0] {
                IDLE, ADDR_BEAT, DATA_BEAT, WAIT_DONE
        } seq_state_t;

endpackage

// File: source/pio_sfifo1f.sv
/*
 * One-entry synchronous queue
 * Single storage register with a valid bit; full and empty
 * come straight from the valid bit
 */

`timescale 1ns/1ps

module pio_sfifo1f #(
        parameter int WIDTH = 16
) (
        input  logic             clk,
        input  logic             reset,
        input  logic [WIDTH-1:0] din,
        input  logic             wr,
        input  logic             rd,
        output logic             full,
        output logic             empty,
        output logic [WIDTH-1:0] dout
);

        logic valid;

        assign full = valid;
        assign empty = ~valid;

        // A push in the same cycle as a pop keeps the entry occupied
        always_ff @(posedge clk) begin
                if (reset) begin
                        valid <= 1'b0;
                end else if (wr) begin
                        valid <= 1'b1;
                end else if (rd) begin
                        valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (wr)
                        dout <= din;
        end

endmodule

// File: source/pio_sequencer.sv
/*
 * PIO transfer sequencer
 * Pops queued AXI-lite requests, reads first, and drives the
 * PIO strobes: one address beat, plus a data beat for writes.
 * Holds until the matching completion before the next transfer
 */

`timescale 1ns/1ps

module pio_sequencer
        import pio_pkg::*;
(
        input  logic      clk,
        input  logic      reset,
        input  logic      waddr_empty,
        input  logic      wdata_empty,
        input  logic      raddr_empty,
        input  pio_word_t waddr,
        input  pio_word_t wdata,
        input  pio_word_t raddr,
        input  logic      rdata_full,
        input  logic      wresp_full,
        input  logic      rdata_push,
        input  logic      wresp_push,
        output logic      waddr_rd,
        output logic      wdata_rd,
        output logic      raddr_rd,
        output logic      pio_start,
        output logic      pio_rw,
        output pio_word_t pio_addr_wdata
);

        seq_state_t state;
        pio_word_t  addr_q;
        pio_word_t  data_q;
        logic       rd_go;
        logic       wr_go;
        logic       done;

        // Read wins; each side needs room in its response queue
        assign rd_go = (state == IDLE) && !raddr_empty && !rdata_full;
        assign wr_go = (state == IDLE) && !waddr_empty && !wdata_empty &&
                       !wresp_full && !rd_go;

        assign raddr_rd = rd_go;
        assign waddr_rd = wr_go;
        assign wdata_rd = wr_go;

        // Completion must match the direction of the open transfer
        assign done = pio_rw ? wresp_push : rdata_push;

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= IDLE;
                        pio_start <= 1'b0;
                        pio_rw <= 1'b0;
                end else begin
                        pio_start <= (state == ADDR_BEAT) || (state == DATA_BEAT);
                        case (state)
                        IDLE: begin
                                if (rd_go) begin
                                        pio_rw <= 1'b0;
                                        state <= ADDR_BEAT;
                                end else if (wr_go) begin
                                        pio_rw <= 1'b1;
                                        state <= ADDR_BEAT;
                                end
                        end
                        ADDR_BEAT:
                                state <= pio_rw ? DATA_BEAT : WAIT_DONE;
                        DATA_BEAT:
                                state <= WAIT_DONE;
                        WAIT_DONE: begin
                                if (done)
                                        state <= IDLE;
                        end
                        default:
                                state <= IDLE;
                        endcase
                end
        end

        // Request payload and the shared address/data bus
        always_ff @(posedge clk) begin
                if (rd_go)
                        addr_q <= raddr;
                else if (wr_go)
                        addr_q <= waddr;
                if (wr_go)
                        data_q <= wdata;
                if (state == ADDR_BEAT)
                        pio_addr_wdata <= addr_q;
                else if (state == DATA_BEAT)
                        pio_addr_wdata <= data_q;
        end

endmodule

// File: source/pio_return_mux.sv
/*
 * PIO return selector
 * Latches each port's ack, rvalid and read data on its own enable,
 * picks the highest port with a level set and turns the rising
 * edge of the selected level into a one-cycle push
 */

`timescale 1ns/1ps

`include "pio_consts.svh"

module pio_return_mux
        import pio_pkg::*;
(
        input  logic      clk,
        input  logic      reset,
        input  pio_mask_t clk_div,
        input  pio_mask_t pio_ack,
        input  pio_mask_t pio_rvalid,
        input  pio_word_t pio_rdata0,
        input  pio_word_t pio_rdata1,
        input  pio_word_t pio_rdata2,
        input  pio_word_t pio_rdata3,
        output logic      rdata_push,
        output logic      wresp_push,
        output pio_word_t rdata
);

        pio_word_t port_rdata [`NUM_OF_PIO];
        pio_word_t lat_rdata [`NUM_OF_PIO];
        pio_mask_t lat_ack;
        pio_mask_t lat_rvalid;
        pio_sel_t  sel_ack;
        pio_sel_t  sel_rd;
        logic      ack_lvl;
        logic      ack_prev;
        logic      rv_lvl;
        logic      rv_prev;

        assign port_rdata[0] = pio_rdata0;
        assign port_rdata[1] = pio_rdata1;
        assign port_rdata[2] = pio_rdata2;
        assign port_rdata[3] = pio_rdata3;

        // Highest set port wins
        always_comb begin
                sel_ack = '0;
                sel_rd = '0;
                for (int i = 0; i < `NUM_OF_PIO; i++) begin
                        if (lat_ack[i])
                                sel_ack = pio_sel_t'(i);
                        if (lat_rvalid[i])
                                sel_rd = pio_sel_t'(i);
                end
        end

        always_ff @(posedge clk) begin
                for (int i = 0; i < `NUM_OF_PIO; i++) begin
                        if (clk_div[i] && pio_rvalid[i])
                                lat_rdata[i] <= port_rdata[i];
                end
                if (lat_rvalid[sel_rd])
                        rdata <= lat_rdata[sel_rd];
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        lat_ack <= '0;
                        lat_rvalid <= '0;
                        ack_lvl <= 1'b0;
                        ack_prev <= 1'b0;
                        rv_lvl <= 1'b0;
                        rv_prev <= 1'b0;
                        wresp_push <= 1'b0;
                        rdata_push <= 1'b0;
                end else begin
                        for (int i = 0; i < `NUM_OF_PIO; i++) begin
                                if (clk_div[i]) begin
                                        lat_ack[i] <= pio_ack[i];
                                        lat_rvalid[i] <= pio_rvalid[i];
                                end
                        end
                        ack_lvl <= lat_ack[sel_ack];
                        rv_lvl <= lat_rvalid[sel_rd];
                        ack_prev <= ack_lvl;
                        rv_prev <= rv_lvl;
                        // Rising edge only, a held level pushes once
                        wresp_push <= ack_lvl & ~ack_prev;
                        rdata_push <= rv_lvl & ~rv_prev;
                end
        end

endmodule

// File: source/pio_bus.sv
/*
 * AXI-lite to PIO bridge
 * One-entry queues on every AXI-lite channel, a sequencer that
 * issues PIO strobes, a return selector for peripheral responses
 * and a free-running prescaled time counter
 */

`timescale 1ns/1ps

`include "pio_consts.svh"

module pio_bus
        import pio_pkg::*;
(
        input  logic       clk,
        input  logic       reset,

        input  pio_word_t  awaddr,
        input  logic       awvalid,
        output logic       awready,
        input  pio_word_t  wdata,
        input  logic       wvalid,
        output logic       wready,
        output logic       bvalid,
        input  logic       bready,
        input  pio_word_t  araddr,
        input  logic       arvalid,
        output logic       arready,
        output pio_word_t  rdata,
        output logic       rvalid,
        input  logic       rready,

        input  pio_mask_t  clk_div,
        input  pio_mask_t  pio_ack,
        input  pio_mask_t  pio_rvalid,
        input  pio_word_t  pio_rdata0,
        input  pio_word_t  pio_rdata1,
        input  pio_word_t  pio_rdata2,
        input  pio_word_t  pio_rdata3,
        output logic       pio_start,
        output logic       pio_rw,
        output pio_word_t  pio_addr_wdata,

        output real_time_t current_time
);

        logic                        waddr_full, waddr_empty, waddr_rd;
        logic                        wdata_full, wdata_empty, wdata_rd;
        logic                        raddr_full, raddr_empty, raddr_rd;
        logic                        rdata_full, rdata_empty, rdata_push;
        logic                        wresp_full, wresp_empty, wresp_push;
        pio_word_t                   waddr_data;
        pio_word_t                   wdata_data;
        pio_word_t                   raddr_data;
        pio_word_t                   ret_rdata;
        logic [`TIME_BASE_NBITS-1:0] time_base;

        //////////////////////////////////////////////////
        // AXI-lite handshakes
        //////////////////////////////////////////////////

        assign awready = ~waddr_full;
        assign wready = ~wdata_full;
        assign arready = ~raddr_full;
        assign rvalid = ~rdata_empty;
        assign bvalid = ~wresp_empty;

        pio_sfifo1f #(.WIDTH(`PIO_NBITS)) waddr_q (
                .clk(clk), .reset(reset),
                .din(awaddr), .wr(awvalid & awready), .rd(waddr_rd),
                .full(waddr_full), .empty(waddr_empty), .dout(waddr_data)
        );

        pio_sfifo1f #(.WIDTH(`PIO_NBITS)) wdata_q (
                .clk(clk), .reset(reset),
                .din(wdata), .wr(wvalid & wready), .rd(wdata_rd),
                .full(wdata_full), .empty(wdata_empty), .dout(wdata_data)
        );

        pio_sfifo1f #(.WIDTH(`PIO_NBITS)) raddr_q (
                .clk(clk), .reset(reset),
                .din(araddr), .wr(arvalid & arready), .rd(raddr_rd),
                .full(raddr_full), .empty(raddr_empty), .dout(raddr_data)
        );

        pio_sfifo1f #(.WIDTH(`PIO_NBITS)) rdata_q (
                .clk(clk), .reset(reset),
                .din(ret_rdata), .wr(rdata_push), .rd(rvalid & rready),
                .full(rdata_full), .empty(rdata_empty), .dout(rdata)
        );

        // Response carries no payload, only its presence
        pio_sfifo1f #(.WIDTH(1)) wresp_q (
                .clk(clk), .reset(reset),
                .din(1'b1), .wr(wresp_push), .rd(bvalid & bready),
                .full(wresp_full), .empty(wresp_empty), .dout()
        );

        //////////////////////////////////////////////////
        // PIO side
        //////////////////////////////////////////////////

        pio_sequencer seq_i (
                .clk(clk), .reset(reset),
                .waddr_empty(waddr_empty), .wdata_empty(wdata_empty),
                .raddr_empty(raddr_empty),
                .waddr(waddr_data), .wdata(wdata_data), .raddr(raddr_data),
                .rdata_full(rdata_full), .wresp_full(wresp_full),
                .rdata_push(rdata_push), .wresp_push(wresp_push),
                .waddr_rd(waddr_rd), .wdata_rd(wdata_rd), .raddr_rd(raddr_rd),
                .pio_start(pio_start), .pio_rw(pio_rw),
                .pio_addr_wdata(pio_addr_wdata)
        );

        pio_return_mux ret_i (
                .clk(clk), .reset(reset),
                .clk_div(clk_div), .pio_ack(pio_ack), .pio_rvalid(pio_rvalid),
                .pio_rdata0(pio_rdata0), .pio_rdata1(pio_rdata1),
                .pio_rdata2(pio_rdata2), .pio_rdata3(pio_rdata3),
                .rdata_push(rdata_push), .wresp_push(wresp_push),
                .rdata(ret_rdata)
        );

        //////////////////////////////////////////////////
        // Time counter
        //////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        time_base <= '0;
                        current_time <= '0;
                end else begin
                        time_base <= time_base + 1'b1;
                        // Tick when the prescaler wraps
                        if (&time_base)
                                current_time <= current_time + 1'b1;
                end
        end

endmodule

// File: verif/pio_bus_checker.sv
/*
 * PIO bridge protocol checker
 * Bound to the bridge top level; checks that responses hold
 * until taken and that PIO strobes follow the beat pattern
 */

`timescale 1ns/1ps

module pio_bus_checker
        import pio_pkg::*;
(
        input logic      clk,
        input logic      reset,
        input logic      bvalid,
        input logic      bready,
        input logic      rvalid,
        input logic      rready,
        input pio_word_t rdata,
        input logic      pio_start,
        input logic      pio_rw
);

        // A response stays offered until the master takes it
        bvalid_held: assert property (@(posedge clk) disable iff (reset)
                bvalid && !bready |=> bvalid)
                else $error("bvalid dropped before bready");

        rvalid_held: assert property (@(posedge clk) disable iff (reset)
                rvalid && !rready |=> rvalid && $stable(rdata))
                else $error("rvalid or rdata changed before rready");

        // Back to back strobes only for the two beats of a write
        start_pairs: assert property (@(posedge clk) disable iff (reset)
                pio_start && $past(pio_start) |-> pio_rw)
                else $error("pio_start high on consecutive cycles of a read");

        start_after_reset: assert property (@(posedge clk)
                reset |=> !pio_start)
                else $error("pio_start high in the cycle after reset");

endmodule

bind pio_bus pio_bus_checker checker_i (
        .clk(clk), .reset(reset),
        .bvalid(bvalid), .bready(bready),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .pio_start(pio_start), .pio_rw(pio_rw)
);

// File: verif/pio_bus_tb.sv
/*
 * AXI-lite to PIO bridge testbench
 * Directed tests through the AXI-lite slave with a behavioral
 * model of four PIO peripherals on staggered clock enables
 */

`timescale 1ns/1ps

`include "pio_consts.svh"

module pio_bus_tb
        import pio_pkg::*;
();

        localparam int RESP_DELAY = 5;
        localparam int MAX_CYCLES = 3000;

        logic        clk;
        logic        reset;
        pio_word_t   awaddr, wdata, araddr, rdata, pio_addr_wdata;
        logic        awvalid, awready, wvalid, wready, bvalid, bready;
        logic        arvalid, arready, rvalid, rready, pio_start, pio_rw;
        real_time_t  current_time;
        pio_mask_t   clk_div = '0;
        pio_mask_t   pio_ack = '0;
        pio_mask_t   pio_rvalid = '0;
        pio_word_t   port_rdata [`NUM_OF_PIO] = '{default: '0};

        // Peripheral model state and strobe log
        int          cycle = 0;
        int          watchdog = 0;
        int          wait_cnt = 0;
        logic        pending = 1'b0;
        logic        wr_phase = 1'b0;
        logic        mod_write = 1'b0;
        pio_sel_t    dport = '0;
        pio_word_t   mod_addr = '0;
        pio_word_t   wr_log [`NUM_OF_PIO];
        logic        start_rw_q [$];
        pio_word_t   start_val_q [$];
        int          b_rise = 0;
        logic        bvalid_prev = 1'b0;
        logic [15:0] lfsr_state;
        int          errors = 0;
        int          tests_run = 0;

        pio_bus dut_i (
                .*,
                .pio_rdata0(port_rdata[0]), .pio_rdata1(port_rdata[1]),
                .pio_rdata2(port_rdata[2]), .pio_rdata3(port_rdata[3])
        );

        always #10 clk = ~clk;

        //////////////////////////////////////////////////
        // Peripheral model
        //////////////////////////////////////////////////

        // Port k is enabled on every (k+1)-th cycle
        always @(negedge clk) begin
                cycle = cycle + 1;
                for (int k = 0; k < `NUM_OF_PIO; k++)
                        clk_div[k] = ((cycle % (k + 1)) == 0);
                if (bvalid && !bvalid_prev)
                        b_rise = b_rise + 1;
                bvalid_prev = bvalid;
                if (reset) begin
                        pending = 1'b0;
                        wr_phase = 1'b0;
                end else if (pio_start) begin
                        start_rw_q.push_back(pio_rw);
                        start_val_q.push_back(pio_addr_wdata);
                        pio_ack = '0;
                        pio_rvalid = '0;
                        wait_cnt = RESP_DELAY;
                        if (pio_rw && wr_phase) begin
                                wr_log[dport] = pio_addr_wdata;
                                wr_phase = 1'b0;
                                pending = 1'b1;
                        end else begin
                                dport = pio_addr_wdata[15:14];
                                mod_addr = pio_addr_wdata;
                                mod_write = pio_rw;
                                wr_phase = pio_rw;
                                pending = !pio_rw;
                        end
                end else if (pending && clk_div[dport]) begin
                        wait_cnt = wait_cnt - 1;
                        if (wait_cnt == 0) begin
                                pending = 1'b0;
                                if (mod_write) begin
                                        pio_ack[dport] = 1'b1;
                                end else begin
                                        port_rdata[dport] = mod_addr ^ 16'hA5A5;
                                        pio_rvalid[dport] = 1'b1;
                                end
                        end
                end
        end

        always @(posedge clk) begin
                watchdog = watchdog + 1;
                if (watchdog >= MAX_CYCLES) begin
                        $display("Timeout: no end of test after %0d cycles", MAX_CYCLES);
                        $display("Finished with errors");
                        $finish;
                end
        end

        //////////////////////////////////////////////////
        // Helpers
        //////////////////////////////////////////////////

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        task automatic take_bits(input int n, output pio_word_t val);
                val = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        val = {val[14:0], lfsr_state[0]};
                end
        endtask

        task automatic report_error(input string msg);
                errors++;
                $display("FAILED at %0t ns: %s", $time, msg);
        endtask

        task automatic axi_write(input pio_word_t addr, input pio_word_t data);
                logic aw_done;
                logic w_done;
                aw_done = 1'b0;
                w_done = 1'b0;
                awaddr = addr;
                wdata = data;
                awvalid = 1'b1;
                wvalid = 1'b1;
                while (!(aw_done && w_done)) begin
                        if (awvalid && awready)
                                aw_done = 1'b1;
                        if (wvalid && wready)
                                w_done = 1'b1;
                        @(negedge clk);
                        if (aw_done)
                                awvalid = 1'b0;
                        if (w_done)
                                wvalid = 1'b0;
                end
        endtask

        task automatic axi_read(input pio_word_t addr);
                araddr = addr;
                arvalid = 1'b1;
                while (!arready)
                        @(negedge clk);
                @(negedge clk);
                arvalid = 1'b0;
        endtask

        task automatic expect_read(input pio_word_t exp);
                rready = 1'b1;
                while (!rvalid)
                        @(negedge clk);
                if (rdata !== exp)
                        report_error($sformatf("rdata is %h, expected %h", rdata, exp));
                @(negedge clk);
                rready = 1'b0;
        endtask

        task automatic take_bresp();
                bready = 1'b1;
                while (!bvalid)
                        @(negedge clk);
                @(negedge clk);
                bready = 1'b0;
        endtask

        task automatic check_strobe(input int idx, input logic rw, input pio_word_t val);
                if (start_rw_q.size() <= idx)
                        report_error($sformatf("PIO strobe %0d never happened", idx));
                else if (start_rw_q[idx] !== rw || start_val_q[idx] !== val)
                        report_error($sformatf("strobe %0d is rw=%b %h, expected rw=%b %h",
                                idx, start_rw_q[idx], start_val_q[idx], rw, val));
        endtask

        //////////////////////////////////////////////////
        // Tests
        //////////////////////////////////////////////////

        task automatic reset_values();
                tests_run++;
                if (pio_start !== 1'b0 || bvalid !== 1'b0 || rvalid !== 1'b0)
                        report_error("pio_start, bvalid or rvalid high after reset");
                if (current_time !== '0)
                        report_error($sformatf("current_time is %0d after reset", current_time));
        endtask

        task automatic write_each_port();
                pio_word_t low;
                pio_word_t data;
                pio_word_t addr;
                int base;
                int b_base;
                tests_run++;
                b_base = b_rise;
                for (int p = 0; p < `NUM_OF_PIO; p++) begin
                        take_bits(14, low);
                        take_bits(16, data);
                        addr = {p[1:0], low[13:0]};
                        base = start_rw_q.size();
                        axi_write(addr, data);
                        take_bresp();
                        if (start_rw_q.size() != base + 2)
                                report_error($sformatf("write to port %0d gave %0d strobes",
                                        p, start_rw_q.size() - base));
                        check_strobe(base, 1'b1, addr);
                        check_strobe(base + 1, 1'b1, data);
                        if (wr_log[p] !== data)
                                report_error($sformatf("port %0d holds %h, expected %h",
                                        p, wr_log[p], data));
                end
                repeat (40) @(negedge clk);
                if (b_rise - b_base != `NUM_OF_PIO || bvalid !== 1'b0)
                        report_error($sformatf("%0d write responses for 4 writes",
                                b_rise - b_base));
        endtask

        task automatic read_each_port();
                pio_word_t low;
                pio_word_t addr;
                int base;
                tests_run++;
                for (int p = 0; p < `NUM_OF_PIO; p++) begin
                        take_bits(14, low);
                        addr = {p[1:0], low[13:0]};
                        base = start_rw_q.size();
                        axi_read(addr);
                        expect_read(addr ^ 16'hA5A5);
                        if (start_rw_q.size() != base + 1)
                                report_error($sformatf("read from port %0d gave %0d strobes",
                                        p, start_rw_q.size() - base));
                        check_strobe(base, 1'b0, addr);
                end
        endtask

        task automatic read_write_collision();
                pio_word_t low;
                pio_word_t data;
                pio_word_t raddr;
                pio_word_t waddr;
                int base;
                tests_run++;
                take_bits(14, low);
                raddr = {2'd3, low[13:0]};
                take_bits(14, low);
                waddr = {2'd1, low[13:0]};
                take_bits(16, data);
                base = start_rw_q.size();
                fork
                        axi_read(raddr);
                        axi_write(waddr, data);
                join
                // The write waits in its queues while the read runs
                if (awready !== 1'b0 || wready !== 1'b0)
                        report_error("awready or wready high with a write still queued");
                fork
                        expect_read(raddr ^ 16'hA5A5);
                        take_bresp();
                join
                // Read strobe must come before both write beats
                check_strobe(base, 1'b0, raddr);
                check_strobe(base + 1, 1'b1, waddr);
                check_strobe(base + 2, 1'b1, data);
                if (wr_log[1] !== data)
                        report_error($sformatf("port 1 holds %h, expected %h", wr_log[1], data));
        endtask

        task automatic read_backpressure();
                pio_word_t a1;
                pio_word_t a2;
                pio_word_t a3;
                int base;
                tests_run++;
                take_bits(16, a1);
                take_bits(16, a2);
                take_bits(16, a3);
                base = start_rw_q.size();
                axi_read(a1);
                while (!rvalid)
                        @(negedge clk);
                axi_read(a2);
                repeat (40) @(negedge clk);
                if (start_rw_q.size() != base + 1)
                        report_error("second read started while read data queue was full");
                if (arready !== 1'b0)
                        report_error("arready high with a read still queued");
                araddr = a3;
                arvalid = 1'b1;
                @(negedge clk);
                arvalid = 1'b0;
                expect_read(a1 ^ 16'hA5A5);
                expect_read(a2 ^ 16'hA5A5);
                check_strobe(base + 1, 1'b0, a2);
        endtask

        task automatic time_counter_rate();
                real_time_t t0;
                int diff;
                tests_run++;
                t0 = current_time;
                repeat (160) @(negedge clk);
                diff = int'(current_time - t0);
                if (diff < 9 || diff > 11)
                        report_error($sformatf("current_time moved %0d in 160 cycles", diff));
        endtask

        initial begin
                clk = 1'b0;
                reset = 1'b1;
                awaddr = '0;
                awvalid = 1'b0;
                wdata = '0;
                wvalid = 1'b0;
                bready = 1'b0;
                araddr = '0;
                arvalid = 1'b0;
                rready = 1'b0;
                lfsr_state = 16'd77;
                repeat (4) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                reset_values();
                write_each_port();
                read_each_port();
                read_write_collision();
                read_backpressure();
                time_counter_rate();
                $display("tests run: %0d, errors: %0d", tests_run, errors);
                if (errors == 0)
                        $display("Finished with no errors");
                else
                        $display("Finished with errors");
                $finish;
        end

endmodule

// File: tb.f
+incdir+source
source/pio_pkg.sv
source/pio_sfifo1f.sv
source/pio_sequencer.sv
source/pio_return_mux.sv
source/pio_bus.sv
verif/pio_bus_checker.sv
verif/pio_bus_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the PIO bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module pio_bus_tb -o pio_bus_sim

out=$(./obj_dir/pio_bus_sim || true)
echo "$out"

# Exit status follows the search for the pass line
echo "$out" | grep -qx "Finished with no errors"
